// ==== Bender.yml ====
package:
  name: hw_manager

sources:
  # RTL in compile order
  - verilog/hw_manager_pkg.sv
  - verilog/board_fault_encoder.sv
  - verilog/fault_arbiter.sv
  - verilog/power_sequencer.sv
  - verilog/hw_manager.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_hw_manager.sv

// ==== compile.f ====
+incdir+tb
verilog/hw_manager_pkg.sv
verilog/board_fault_encoder.sv
verilog/fault_arbiter.sv
verilog/power_sequencer.sv
verilog/hw_manager.sv
tb/tb_hw_manager.sv

// ==== tb/tb_hw_manager_tasks.svh ====
`ifndef TB_HW_MANAGER_TASKS_SVH
`define TB_HW_MANAGER_TASKS_SVH

// Report, fail message and stop
task automatic stop_run(input string why);
  $display("%s", why);
  $display("TEST RESULT: FAIL");
  $fatal(1, "Stopped at the first error");
endtask

task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    stop_run($sformatf("FAIL at %0t ns: %s is 0x%0h, expected 0x%0h",
                       $time, what, got, exp));
  end
endtask

// Polls at falling edges, returns on the first one in the target state
task automatic wait_state(input hw_manager_pkg::hw_state_t target, input string what);
  int unsigned n;
  n = 0;
  @(negedge clk);
  while (status_word.state !== target) begin
    if (n >= WAIT_LIMIT) begin
      stop_run($sformatf("State %0d never reached while waiting for %s", target, what));
    end
    n++;
    @(negedge clk);
  end
endtask

// Enable with SPI reporting off, up to the SPI start check
task automatic power_to_spi_start();
  @(posedge clk);
  spi_off <= 1'b1;
  sys_en  <= 1'b1;
  wait_state(hw_manager_pkg::ST_CONFIRM_SPI_INIT, "enable");
  check("config locked", power_ctrl.unlock_cfg, 1'b0);
  wait_state(hw_manager_pkg::ST_RELEASE_SD_F, "SPI off seen");
  check("force released", power_ctrl.n_shutdown_force, 1'b1);
  wait_state(hw_manager_pkg::ST_PULSE_SD_RST, "force delay");
  check("reset pulse low", power_ctrl.n_shutdown_rst, 1'b0);
  wait_state(hw_manager_pkg::ST_SD_RST_DELAY, "reset pulse");
  check("reset pulse high", power_ctrl.n_shutdown_rst, 1'b1);
  wait_state(hw_manager_pkg::ST_CONFIRM_SPI_START, "reset delay");
  check("SPI enabled", power_ctrl.spi_en, 1'b1);
endtask

task automatic power_up();
  int unsigned irq_before;
  irq_before = irq_count;
  power_to_spi_start();
  @(posedge clk);
  spi_off <= 1'b0;  // SPI reports on
  wait_state(hw_manager_pkg::ST_RUNNING, "SPI on");
  check("running code", status_word.code, hw_manager_pkg::STS_OK);
  check("running power_ctrl", power_ctrl, PC_RUN);
  check("running interrupt", ps_interrupt, 1'b1);
  @(negedge clk);
  check("interrupt one cycle", ps_interrupt, 1'b0);
  check("power-up interrupt count", irq_count - irq_before, 1);
endtask

// Drop enable and every fault input, expect a cleared IDLE
task automatic power_down();
  @(posedge clk);
  sys_en       <= 1'b0;
  ext_shutdown <= 1'b0;
  lock_viol    <= 1'b0;
  cfg_faults   <= '0;
  for (int i = 0; i < N_BOARDS; i++) begin
    board_faults[i] <= '0;
  end
  wait_state(hw_manager_pkg::ST_IDLE, "enable low");
  check("idle code", status_word.code, hw_manager_pkg::STS_OK);
  check("idle board", status_word.board_num, 0);
  check("idle power_ctrl", power_ctrl, PC_IDLE);
endtask

task automatic test_reset_power_up();
  @(negedge clk);
  check("reset state", status_word.state, hw_manager_pkg::ST_IDLE);
  check("reset code", status_word.code, hw_manager_pkg::STS_OK);
  check("reset board", status_word.board_num, 0);
  check("reset power_ctrl", power_ctrl, PC_IDLE);
  check("reset interrupt", ps_interrupt, 1'b0);
  power_up();
  power_down();
endtask

task automatic test_cfg_refusal();
  hw_manager_pkg::cfg_faults_t  cfg;
  hw_manager_pkg::status_code_t exp_code;
  for (int r = 0; r < CFG_ROUNDS; r++) begin
    cfg = 4'($random(seed));
    if (cfg == '0) begin
      cfg.sys_en_oob = 1'b1;
    end
    // First set flag from the top wins
    if (cfg.integ_thresh_avg_oob) begin
      exp_code = hw_manager_pkg::STS_INTEG_THRESH_AVG_OOB;
    end else if (cfg.integ_window_oob) begin
      exp_code = hw_manager_pkg::STS_INTEG_WINDOW_OOB;
    end else if (cfg.integ_en_oob) begin
      exp_code = hw_manager_pkg::STS_INTEG_EN_OOB;
    end else begin
      exp_code = hw_manager_pkg::STS_SYS_EN_OOB;
    end
    @(posedge clk);
    cfg_faults <= cfg;
    sys_en     <= 1'b1;
    wait_state(hw_manager_pkg::ST_HALTED, "config refusal");
    check("refusal code", status_word.code, exp_code);
    check("refusal power_ctrl", power_ctrl, PC_IDLE);
    check("refusal interrupt", ps_interrupt, 1'b1);
    power_down();
  end
endtask

task automatic test_spi_timeouts();
  @(posedge clk);
  spi_off <= 1'b0;  // Never reports off
  sys_en  <= 1'b1;
  wait_state(hw_manager_pkg::ST_HALTED, "SPI init timeout");
  check("init timeout code", status_word.code, hw_manager_pkg::STS_SPI_INIT_TIMEOUT);
  check("init timeout power_ctrl", power_ctrl, PC_OFF);
  check("init timeout interrupt", ps_interrupt, 1'b1);
  power_down();
  power_to_spi_start();  // spi_off stays high from here
  wait_state(hw_manager_pkg::ST_HALTED, "SPI start timeout");
  check("start timeout code", status_word.code, hw_manager_pkg::STS_SPI_START_TIMEOUT);
  check("start timeout power_ctrl", power_ctrl, PC_OFF);
  check("start timeout interrupt", ps_interrupt, 1'b1);
  power_down();
endtask

task automatic test_fault_priority();
  hw_manager_pkg::board_faults_t flags [N_BOARDS];
  hw_manager_pkg::status_code_t  exp_code;
  int unsigned                   exp_flag;
  int unsigned                   exp_board;
  int unsigned                   n_flags;
  int unsigned                   b;
  int unsigned                   k;
  logic                          ext;
  logic                          lock;
  for (int r = 0; r < FAULT_ROUNDS; r++) begin
    power_up();
    for (int i = 0; i < N_BOARDS; i++) begin
      flags[i] = '0;
    end
    n_flags = 1 + $unsigned($random(seed)) % 3;
    for (int f = 0; f < n_flags; f++) begin
      b = $unsigned($random(seed)) % N_BOARDS;
      k = $unsigned($random(seed)) % 10;
      flags[b][9 - k] = 1'b1;  // Flag 0 sits in the top bit
    end
    ext  = 1'($random(seed));
    lock = (r % 4 == 3);  // Some rounds add a lock violation on top
    // Lowest flag index first, then lowest board
    exp_flag  = 10;
    exp_board = 0;
    for (int kk = 0; kk < 10; kk++) begin
      for (int bb = 0; bb < N_BOARDS; bb++) begin
        if (flags[bb][9 - kk] && exp_flag == 10) begin
          exp_flag  = kk;
          exp_board = bb;
        end
      end
    end
    if (lock) begin
      exp_code  = hw_manager_pkg::STS_LOCK_VIOL;  // Outranks every board flag
      exp_board = 0;
    end else if (ext && exp_flag != 0) begin
      exp_code  = hw_manager_pkg::STS_EXT_SHUTDOWN;
      exp_board = 0;  // Board field keeps its cleared value
    end else begin
      exp_code = board_flag_code(exp_flag);
    end
    @(posedge clk);
    for (int i = 0; i < N_BOARDS; i++) begin
      board_faults[i] <= flags[i];
    end
    ext_shutdown <= ext;
    lock_viol    <= lock;
    repeat (2) @(negedge clk);  // Seen at the next edge, halted after it
    check("fault halt state", status_word.state, hw_manager_pkg::ST_HALTED);
    check("fault code", status_word.code, exp_code);
    check("fault board", status_word.board_num, exp_board);
    check("fault power_ctrl", power_ctrl, PC_OFF);
    check("fault interrupt", ps_interrupt, 1'b1);
    @(negedge clk);
    check("fault interrupt one cycle", ps_interrupt, 1'b0);
    power_down();
  end
endtask

task automatic test_recovery();
  hw_manager_pkg::board_faults_t f;
  f             = '0;
  f.dac_val_oob = 1'b1;
  power_up();
  @(posedge clk);
  board_faults[5] <= f;
  wait_state(hw_manager_pkg::ST_HALTED, "board 5 fault");
  check("recovery fault code", status_word.code, hw_manager_pkg::STS_DAC_VAL_OOB);
  check("recovery fault board", status_word.board_num, 5);
  power_down();  // Cleared status, config unlocked
  power_up();
  @(posedge clk);
  sys_en <= 1'b0;  // Normal shutdown from RUNNING
  repeat (2) @(negedge clk);
  check("shutdown state", status_word.state, hw_manager_pkg::ST_HALTED);
  check("shutdown code", status_word.code, hw_manager_pkg::STS_PS_SHUTDOWN);
  wait_state(hw_manager_pkg::ST_IDLE, "return to idle");
  check("final power_ctrl", power_ctrl, PC_IDLE);
endtask

`endif

// ==== tb/tb_hw_manager.sv ====
`timescale 1ns/100ps
`default_nettype none

// Directed testbench for the hardware manager
module tb_hw_manager;

  localparam int unsigned N_BOARDS     = 8;
  localparam int unsigned FORCE_DELAY  = 4;
  localparam int unsigned RST_PULSE    = 3;
  localparam int unsigned RST_DELAY    = 5;
  localparam int unsigned INIT_WAIT    = 16;  // Must exceed SPI_MIN_INIT
  localparam int unsigned START_WAIT   = 12;
  localparam int unsigned CFG_ROUNDS   = 3;
  localparam int unsigned FAULT_ROUNDS = 8;

  // One power-up with both SPI waits run out, plus slack per state
  localparam int unsigned SEQ_CYCLES = hw_manager_pkg::SPI_MIN_INIT + FORCE_DELAY
                                       + RST_PULSE + RST_DELAY + INIT_WAIT + START_WAIT + 16;
  localparam int unsigned N_SEQUENCES    = 1 + CFG_ROUNDS + 2 + FAULT_ROUNDS + 2;
  localparam int unsigned TIMEOUT_CYCLES = N_SEQUENCES * SEQ_CYCLES + 200;
  localparam int unsigned WAIT_LIMIT     = SEQ_CYCLES;  // Any single state wait

  // Bit order unlock_cfg, spi_clk_power_n, spi_en, sense_en, trig_en, n_force, n_rst
  localparam logic [6:0] PC_IDLE = 7'b1100001;  // Unlocked, all held off
  localparam logic [6:0] PC_RUN  = 7'b0011111;
  localparam logic [6:0] PC_OFF  = 7'b0100001;  // Locked, powered down

  logic                          clk;
  logic                          aresetn;
  logic                          sys_en;
  logic                          spi_off;
  logic                          ext_shutdown;
  logic                          lock_viol;
  hw_manager_pkg::cfg_faults_t   cfg_faults;
  hw_manager_pkg::board_faults_t board_faults [N_BOARDS];
  hw_manager_pkg::power_ctrl_t   power_ctrl;
  hw_manager_pkg::status_word_t  status_word;
  logic                          ps_interrupt;

  integer      seed;
  int unsigned cycle_count = 0;
  int unsigned irq_count   = 0;  // Interrupt pulses seen so far

  hw_manager #(
    .N_BOARDS             (N_BOARDS),
    .SHUTDOWN_FORCE_DELAY (FORCE_DELAY),
    .SHUTDOWN_RESET_PULSE (RST_PULSE),
    .SHUTDOWN_RESET_DELAY (RST_DELAY),
    .SPI_INIT_WAIT        (INIT_WAIT),
    .SPI_START_WAIT       (START_WAIT)
  ) dut_i (
    .clk          (clk),
    .aresetn      (aresetn),
    .sys_en       (sys_en),
    .spi_off      (spi_off),
    .ext_shutdown (ext_shutdown),
    .lock_viol    (lock_viol),
    .cfg_faults   (cfg_faults),
    .board_faults (board_faults),
    .power_ctrl   (power_ctrl),
    .status_word  (status_word),
    .ps_interrupt (ps_interrupt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 125 MHz
  end

  // Registered view, so a pulse is counted one edge after it starts
  always @(posedge clk) begin
    if (ps_interrupt) begin
      irq_count <= irq_count + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycle_count);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  // Status code of board flag k, k counted in priority order
  function automatic hw_manager_pkg::status_code_t board_flag_code(input int unsigned k);
    case (k)
      0:       return hw_manager_pkg::STS_SHUTDOWN_SENSE;
      1:       return hw_manager_pkg::STS_OVER_THRESH;
      2:       return hw_manager_pkg::STS_THRESH_UNDERFLOW;
      3:       return hw_manager_pkg::STS_THRESH_OVERFLOW;
      4:       return hw_manager_pkg::STS_BAD_DAC_CMD;
      5:       return hw_manager_pkg::STS_DAC_CAL_OOB;
      6:       return hw_manager_pkg::STS_DAC_VAL_OOB;
      7:       return hw_manager_pkg::STS_DAC_BUF_UNDERFLOW;
      8:       return hw_manager_pkg::STS_DAC_BUF_OVERFLOW;
      default: return hw_manager_pkg::STS_UNEXP_DAC_TRIG;
    endcase
  endfunction

  `include "tb_hw_manager_tasks.svh"

  initial begin
    seed         = 32'h0f0215f0;
    aresetn      = 1'b0;
    sys_en       = 1'b0;
    spi_off      = 1'b1;
    ext_shutdown = 1'b0;
    lock_viol    = 1'b0;
    cfg_faults   = '0;
    for (int i = 0; i < N_BOARDS; i++) begin
      board_faults[i] = '0;
    end
    repeat (3) @(posedge clk);  // Reset held for 3 cycles
    aresetn <= 1'b1;

    test_reset_power_up();
    test_cfg_refusal();
    test_spi_timeouts();
    test_fault_priority();
    test_recovery();

    $display("Directed tests finished after %0d cycles", cycle_count);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/board_fault_encoder.sv ====
`timescale 1ns/100ps
`default_nettype none

// Priority encoder for one board's fault flags
module board_fault_encoder (
  input  wire hw_manager_pkg::board_faults_t faults,
  output hw_manager_pkg::fault_cause_t       cause   // Index of first set flag
);

  // First set flag in priority order wins
  always_comb begin
    case (1'b1)
      faults.shutdown_sense:
        cause = hw_manager_pkg::CAUSE_SHUTDOWN_SENSE;
      faults.over_thresh:
        cause = hw_manager_pkg::CAUSE_OVER_THRESH;      // Integrator threshold
      faults.thresh_underflow:
        cause = hw_manager_pkg::CAUSE_THRESH_UNDERFLOW;
      faults.thresh_overflow:
        cause = hw_manager_pkg::CAUSE_THRESH_OVERFLOW;
      faults.bad_dac_cmd:
        cause = hw_manager_pkg::CAUSE_BAD_DAC_CMD;      // DAC command path
      faults.dac_cal_oob:
        cause = hw_manager_pkg::CAUSE_DAC_CAL_OOB;
      faults.dac_val_oob:
        cause = hw_manager_pkg::CAUSE_DAC_VAL_OOB;
      faults.dac_cmd_buf_underflow:
        cause = hw_manager_pkg::CAUSE_DAC_BUF_UNDERFLOW;
      faults.dac_cmd_buf_overflow:
        cause = hw_manager_pkg::CAUSE_DAC_BUF_OVERFLOW;
      faults.unexp_dac_trig:
        cause = hw_manager_pkg::CAUSE_UNEXP_DAC_TRIG;
      default:
        cause = hw_manager_pkg::CAUSE_NONE;             // Board healthy
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/fault_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

// Picks the winning fault over all boards
// Lowest cause index first, then lowest board number
module fault_arbiter #(
  parameter int unsigned N_BOARDS = 8
) (
  input  wire hw_manager_pkg::fault_cause_t causes [N_BOARDS], // One per board
  output hw_manager_pkg::arb_result_t       arb
);

  localparam int BW = hw_manager_pkg::BOARD_W;

  // Board index must fit the status word board field
  if (N_BOARDS < 1 || N_BOARDS > hw_manager_pkg::MAX_BOARDS) begin : g_bad_boards
    $error("fault_arbiter: N_BOARDS %0d outside 1..%0d",
           N_BOARDS, hw_manager_pkg::MAX_BOARDS);
  end

  always_comb begin
    hw_manager_pkg::fault_cause_t best_cause;
    logic [BW-1:0]                best_board;

    best_cause = hw_manager_pkg::CAUSE_NONE;  // CAUSE_NONE sorts last
    best_board = '0;

    // Ascending scan, strict compare keeps lower board on a tie
    for (int b = 0; b < N_BOARDS; b++) begin
      if (causes[b] < best_cause) begin
        best_cause = causes[b];
        best_board = BW'(b);
      end
    end

    arb.any   = (best_cause != hw_manager_pkg::CAUSE_NONE);
    arb.cause = best_cause;
    arb.board = best_board;   // Zero when nothing faulted
  end

endmodule

`default_nettype wire

// ==== verilog/hw_manager.sv ====
`timescale 1ns/100ps
`default_nettype none

// Hardware manager top
// Board encoders feed one arbiter, which feeds the sequencer
module hw_manager #(
  parameter int unsigned N_BOARDS             = 8,
  parameter int unsigned SHUTDOWN_FORCE_DELAY = 25000000,
  parameter int unsigned SHUTDOWN_RESET_PULSE = 25000,
  parameter int unsigned SHUTDOWN_RESET_DELAY = 25000000,
  parameter int unsigned SPI_INIT_WAIT        = 25000000,
  parameter int unsigned SPI_START_WAIT       = 250000000
) (
  input  wire                                clk,
  input  wire                                aresetn,
  input  wire                                sys_en,
  input  wire                                spi_off,
  input  wire                                ext_shutdown,
  input  wire                                lock_viol,
  input  wire hw_manager_pkg::cfg_faults_t   cfg_faults,
  input  wire hw_manager_pkg::board_faults_t board_faults [N_BOARDS],
  output wire hw_manager_pkg::power_ctrl_t   power_ctrl,
  output wire hw_manager_pkg::status_word_t  status_word,
  output wire                                ps_interrupt
);

  hw_manager_pkg::fault_cause_t causes [N_BOARDS];  // Per-board winner
  hw_manager_pkg::arb_result_t  arb;

  // One encoder per board
  for (genvar i = 0; i < N_BOARDS; i++) begin : g_board
    board_fault_encoder enc_i (
      .faults (board_faults[i]),
      .cause  (causes[i])
    );
  end

  fault_arbiter #(
    .N_BOARDS (N_BOARDS)
  ) arb_i (
    .causes (causes),
    .arb    (arb)
  );

  power_sequencer #(
    .SHUTDOWN_FORCE_DELAY (SHUTDOWN_FORCE_DELAY),
    .SHUTDOWN_RESET_PULSE (SHUTDOWN_RESET_PULSE),
    .SHUTDOWN_RESET_DELAY (SHUTDOWN_RESET_DELAY),
    .SPI_INIT_WAIT        (SPI_INIT_WAIT),
    .SPI_START_WAIT       (SPI_START_WAIT)
  ) seq_i (
    .clk          (clk),
    .aresetn      (aresetn),
    .sys_en       (sys_en),
    .spi_off      (spi_off),
    .ext_shutdown (ext_shutdown),
    .lock_viol    (lock_viol),
    .cfg_faults   (cfg_faults),
    .arb          (arb),
    .power_ctrl   (power_ctrl),
    .status_word  (status_word),
    .ps_interrupt (ps_interrupt)
  );

endmodule

`default_nettype wire

// ==== verilog/hw_manager_pkg.sv ====
`default_nettype none

package hw_manager_pkg;

  localparam int unsigned MAX_BOARDS   = 8;  // Limited by board field width
  localparam int unsigned BOARD_W      = 3;
  localparam int unsigned SPI_MIN_INIT = 10; // Cycles before spi_off is trusted

  // Sequencer states, values shared with software
  typedef enum logic [3:0] {
    ST_IDLE              = 4'd1,
    ST_CONFIRM_SPI_INIT  = 4'd2,
    ST_RELEASE_SD_F      = 4'd3,
    ST_PULSE_SD_RST      = 4'd4,
    ST_SD_RST_DELAY      = 4'd5,
    ST_CONFIRM_SPI_START = 4'd6,
    ST_RUNNING           = 4'd7,
    ST_HALTED            = 4'd8
  } hw_state_t;

  // Status codes, upper byte groups the subsystem
  typedef enum logic [24:0] {
    STS_OK                   = 25'h0001,
    STS_PS_SHUTDOWN          = 25'h0002,
    STS_SPI_START_TIMEOUT    = 25'h0100,
    STS_SPI_INIT_TIMEOUT     = 25'h0101,
    STS_INTEG_THRESH_AVG_OOB = 25'h0200,
    STS_INTEG_WINDOW_OOB     = 25'h0201,
    STS_INTEG_EN_OOB         = 25'h0202,
    STS_SYS_EN_OOB           = 25'h0203,
    STS_LOCK_VIOL            = 25'h0204,
    STS_SHUTDOWN_SENSE       = 25'h0300,
    STS_EXT_SHUTDOWN         = 25'h0301,
    STS_OVER_THRESH          = 25'h0400,
    STS_THRESH_UNDERFLOW     = 25'h0401,
    STS_THRESH_OVERFLOW      = 25'h0402,
    STS_BAD_DAC_CMD          = 25'h0600,
    STS_DAC_CAL_OOB          = 25'h0601,
    STS_DAC_VAL_OOB          = 25'h0602,
    STS_DAC_BUF_UNDERFLOW    = 25'h0603,
    STS_DAC_BUF_OVERFLOW     = 25'h0604,
    STS_UNEXP_DAC_TRIG       = 25'h0605
  } status_code_t;

  typedef struct packed {
    logic [BOARD_W-1:0] board_num; // Top bits
    status_code_t       code;
    hw_state_t          state;
  } status_word_t;

  // Per-board flags, highest priority first
  typedef struct packed {
    logic shutdown_sense;
    logic over_thresh;
    logic thresh_underflow;
    logic thresh_overflow;
    logic bad_dac_cmd;
    logic dac_cal_oob;
    logic dac_val_oob;
    logic dac_cmd_buf_underflow;
    logic dac_cmd_buf_overflow;
    logic unexp_dac_trig;
  } board_faults_t;

  // Index into board flags, lower wins
  typedef enum logic [3:0] {
    CAUSE_SHUTDOWN_SENSE   = 4'd0,
    CAUSE_OVER_THRESH      = 4'd1,
    CAUSE_THRESH_UNDERFLOW = 4'd2,
    CAUSE_THRESH_OVERFLOW  = 4'd3,
    CAUSE_BAD_DAC_CMD      = 4'd4,
    CAUSE_DAC_CAL_OOB      = 4'd5,
    CAUSE_DAC_VAL_OOB      = 4'd6,
    CAUSE_DAC_BUF_UNDERFLOW = 4'd7,
    CAUSE_DAC_BUF_OVERFLOW = 4'd8,
    CAUSE_UNEXP_DAC_TRIG   = 4'd9,
    CAUSE_NONE             = 4'd15
  } fault_cause_t;

  typedef struct packed {
    logic               any;   // At least one board faulted
    fault_cause_t       cause;
    logic [BOARD_W-1:0] board;
  } arb_result_t;

  // Pre-start config checks, highest priority first
  typedef struct packed {
    logic integ_thresh_avg_oob;
    logic integ_window_oob;
    logic integ_en_oob;
    logic sys_en_oob;
  } cfg_faults_t;

  typedef struct packed {
    logic unlock_cfg;
    logic spi_clk_power_n;   // Active low
    logic spi_en;
    logic shutdown_sense_en;
    logic trig_en;
    logic n_shutdown_force;  // Active low
    logic n_shutdown_rst;    // Active low
  } power_ctrl_t;

  // Board fault cause to reported status code
  function automatic status_code_t cause_code(fault_cause_t cause);
    case (cause)
      CAUSE_SHUTDOWN_SENSE:    cause_code = STS_SHUTDOWN_SENSE;
      CAUSE_OVER_THRESH:       cause_code = STS_OVER_THRESH;
      CAUSE_THRESH_UNDERFLOW:  cause_code = STS_THRESH_UNDERFLOW;
      CAUSE_THRESH_OVERFLOW:   cause_code = STS_THRESH_OVERFLOW;
      CAUSE_BAD_DAC_CMD:       cause_code = STS_BAD_DAC_CMD;
      CAUSE_DAC_CAL_OOB:       cause_code = STS_DAC_CAL_OOB;
      CAUSE_DAC_VAL_OOB:       cause_code = STS_DAC_VAL_OOB;
      CAUSE_DAC_BUF_UNDERFLOW: cause_code = STS_DAC_BUF_UNDERFLOW;
      CAUSE_DAC_BUF_OVERFLOW:  cause_code = STS_DAC_BUF_OVERFLOW;
      CAUSE_UNEXP_DAC_TRIG:    cause_code = STS_UNEXP_DAC_TRIG;
      default:                 cause_code = STS_OK; // No fault
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== verilog/power_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

// Power-up sequence, run-time fault halt and status reporting
module power_sequencer #(
  parameter int unsigned SHUTDOWN_FORCE_DELAY = 25000000,  // 100 ms at 250 MHz
  parameter int unsigned SHUTDOWN_RESET_PULSE = 25000,     // 100 us
  parameter int unsigned SHUTDOWN_RESET_DELAY = 25000000,  // 100 ms
  parameter int unsigned SPI_INIT_WAIT        = 25000000,  // 100 ms
  parameter int unsigned SPI_START_WAIT       = 250000000  // 1 s
) (
  input  wire                              clk,
  input  wire                              aresetn,
  input  wire                              sys_en,
  input  wire                              spi_off,       // SPI subsystem reports off
  input  wire                              ext_shutdown,
  input  wire                              lock_viol,
  input  wire hw_manager_pkg::cfg_faults_t cfg_faults,
  input  wire hw_manager_pkg::arb_result_t arb,           // Winning board fault
  output hw_manager_pkg::power_ctrl_t      power_ctrl,
  output hw_manager_pkg::status_word_t     status_word,
  output logic                             ps_interrupt
);

  localparam int BW = hw_manager_pkg::BOARD_W;

  // Safe state, config unlocked and everything held off
  localparam hw_manager_pkg::power_ctrl_t PC_RESET = '{
    unlock_cfg:        1'b1,
    spi_clk_power_n:   1'b1,
    spi_en:            1'b0,
    shutdown_sense_en: 1'b0,
    trig_en:           1'b0,
    n_shutdown_force:  1'b0,
    n_shutdown_rst:    1'b1
  };

  hw_manager_pkg::hw_state_t    state_q;
  logic [31:0]                  timer_q;  // Cleared on every state change
  hw_manager_pkg::status_code_t code_q;
  logic [BW-1:0]                board_q;

  hw_manager_pkg::status_code_t cfg_code;  // Config refusal code
  logic                         cfg_bad;
  hw_manager_pkg::status_code_t run_code;  // Run-time halt code
  logic [BW-1:0]                run_board;
  logic                         run_halt;

  assign status_word = '{board_num: board_q, code: code_q, state: state_q};

  // Config checks in fixed priority
  always_comb begin
    cfg_bad = |cfg_faults;
    case (1'b1)
      cfg_faults.integ_thresh_avg_oob: cfg_code = hw_manager_pkg::STS_INTEG_THRESH_AVG_OOB;
      cfg_faults.integ_window_oob:     cfg_code = hw_manager_pkg::STS_INTEG_WINDOW_OOB;
      cfg_faults.integ_en_oob:         cfg_code = hw_manager_pkg::STS_INTEG_EN_OOB;
      cfg_faults.sys_en_oob:           cfg_code = hw_manager_pkg::STS_SYS_EN_OOB;
      default:                         cfg_code = hw_manager_pkg::STS_OK;
    endcase
  end

  // Halt decision while running
  // Shutdown sense outranks ext_shutdown, other board faults rank below it
  always_comb begin
    run_halt  = 1'b1;
    run_board = board_q;  // Kept unless a board is to blame
    if (!sys_en) begin
      run_code = hw_manager_pkg::STS_PS_SHUTDOWN;     // Normal power-down request
    end else if (lock_viol) begin
      run_code = hw_manager_pkg::STS_LOCK_VIOL;
    end else if (arb.any && arb.cause == hw_manager_pkg::CAUSE_SHUTDOWN_SENSE) begin
      run_code  = hw_manager_pkg::STS_SHUTDOWN_SENSE;
      run_board = arb.board;
    end else if (ext_shutdown) begin
      run_code = hw_manager_pkg::STS_EXT_SHUTDOWN;
    end else if (arb.any) begin
      run_code  = hw_manager_pkg::cause_code(arb.cause);
      run_board = arb.board;
    end else begin
      run_halt = 1'b0;
      run_code = code_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state_q      <= hw_manager_pkg::ST_IDLE;
      timer_q      <= '0;
      code_q       <= hw_manager_pkg::STS_OK;
      board_q      <= '0;
      power_ctrl   <= PC_RESET;
      ps_interrupt <= 1'b0;
    end else begin
      ps_interrupt <= 1'b0;  // Pulse only on entry to RUNNING or HALTED
      case (state_q)
        hw_manager_pkg::ST_IDLE: begin
          if (sys_en && cfg_bad) begin
            state_q      <= hw_manager_pkg::ST_HALTED;  // Refuse, config stays unlocked
            code_q       <= cfg_code;
            ps_interrupt <= 1'b1;
          end else if (sys_en) begin
            state_q                    <= hw_manager_pkg::ST_CONFIRM_SPI_INIT;
            timer_q                    <= '0;
            power_ctrl.unlock_cfg      <= 1'b0;  // Lock config
            power_ctrl.spi_clk_power_n <= 1'b0;  // Clock on to read spi_off
          end
        end

        hw_manager_pkg::ST_CONFIRM_SPI_INIT: begin
          if (timer_q >= hw_manager_pkg::SPI_MIN_INIT && spi_off) begin
            state_q                     <= hw_manager_pkg::ST_RELEASE_SD_F;
            timer_q                     <= '0;
            power_ctrl.spi_clk_power_n  <= 1'b1;
            power_ctrl.n_shutdown_force <= 1'b1;  // Release the force
          end else if (timer_q >= SPI_INIT_WAIT) begin
            state_q                    <= hw_manager_pkg::ST_HALTED;
            timer_q                    <= '0;
            power_ctrl.spi_clk_power_n <= 1'b1;
            code_q                     <= hw_manager_pkg::STS_SPI_INIT_TIMEOUT;
            ps_interrupt               <= 1'b1;
          end else begin
            timer_q <= timer_q + 32'd1;
          end
        end

        hw_manager_pkg::ST_RELEASE_SD_F: begin
          if (timer_q >= SHUTDOWN_FORCE_DELAY) begin
            state_q                   <= hw_manager_pkg::ST_PULSE_SD_RST;
            timer_q                   <= '0;
            power_ctrl.n_shutdown_rst <= 1'b0;  // Reset pulse start
          end else begin
            timer_q <= timer_q + 32'd1;
          end
        end

        hw_manager_pkg::ST_PULSE_SD_RST: begin
          if (timer_q >= SHUTDOWN_RESET_PULSE) begin
            state_q                   <= hw_manager_pkg::ST_SD_RST_DELAY;
            timer_q                   <= '0;
            power_ctrl.n_shutdown_rst <= 1'b1;  // Reset pulse end
          end else begin
            timer_q <= timer_q + 32'd1;
          end
        end

        hw_manager_pkg::ST_SD_RST_DELAY: begin
          if (timer_q >= SHUTDOWN_RESET_DELAY) begin
            state_q                      <= hw_manager_pkg::ST_CONFIRM_SPI_START;
            timer_q                      <= '0;
            power_ctrl.shutdown_sense_en <= 1'b1;
            power_ctrl.spi_clk_power_n   <= 1'b0;
            power_ctrl.spi_en            <= 1'b1;
          end else begin
            timer_q <= timer_q + 32'd1;
          end
        end

        hw_manager_pkg::ST_CONFIRM_SPI_START: begin
          if (!spi_off) begin
            state_q            <= hw_manager_pkg::ST_RUNNING;  // SPI came up
            timer_q            <= '0;
            power_ctrl.trig_en <= 1'b1;
            ps_interrupt       <= 1'b1;
          end else if (timer_q >= SPI_START_WAIT) begin
            state_q                      <= hw_manager_pkg::ST_HALTED;
            timer_q                      <= '0;
            power_ctrl.n_shutdown_force  <= 1'b0;
            power_ctrl.shutdown_sense_en <= 1'b0;
            power_ctrl.spi_clk_power_n   <= 1'b1;
            power_ctrl.spi_en            <= 1'b0;
            code_q                       <= hw_manager_pkg::STS_SPI_START_TIMEOUT;
            ps_interrupt                 <= 1'b1;
          end else begin
            timer_q <= timer_q + 32'd1;
          end
        end

        hw_manager_pkg::ST_RUNNING: begin
          if (run_halt) begin
            state_q                      <= hw_manager_pkg::ST_HALTED;
            code_q                       <= run_code;
            board_q                      <= run_board;
            power_ctrl.n_shutdown_force  <= 1'b0;  // Everything off at once
            power_ctrl.shutdown_sense_en <= 1'b0;
            power_ctrl.spi_clk_power_n   <= 1'b1;
            power_ctrl.spi_en            <= 1'b0;
            power_ctrl.trig_en           <= 1'b0;
            ps_interrupt                 <= 1'b1;
          end
        end

        hw_manager_pkg::ST_HALTED: begin
          // Stay until software drops the enable
          if (!sys_en) begin
            state_q               <= hw_manager_pkg::ST_IDLE;
            code_q                <= hw_manager_pkg::STS_OK;
            board_q               <= '0;
            power_ctrl.unlock_cfg <= 1'b1;
          end
        end

        default: begin
          state_q <= hw_manager_pkg::ST_IDLE;  // Illegal encoding
          timer_q <= '0;
        end
      endcase
    end
  end

  // Triggers only while running, including the halt edge
  a_trig_only_running: assert property (@(posedge clk) disable iff (!aresetn)
    power_ctrl.trig_en |-> state_q == hw_manager_pkg::ST_RUNNING);

  // Interrupt is a single-cycle pulse
  a_irq_one_cycle: assert property (@(posedge clk) disable iff (!aresetn)
    ps_interrupt |=> !ps_interrupt);

  a_rst_pulse_state: assert property (@(posedge clk) disable iff (!aresetn)
    !power_ctrl.n_shutdown_rst |-> state_q == hw_manager_pkg::ST_PULSE_SD_RST);

endmodule

`default_nettype wire
